/* all.f */
+incdir+source
source/axi_excl_pkg.sv
source/axi_link_if.sv
source/axi_req_slice.sv
source/axi_exclusive_monitor.sv
source/axi_sram_slave.sv
source/axi_excl_top.sv
bench/axi_excl_chk.sv
bench/axi_excl_tb.sv

/* Bender.yml */
package:
  name: axi_excl

sources:
  - include_dirs:
      - source
    files:
      - source/axi_excl_pkg.sv
      - source/axi_link_if.sv
      - source/axi_req_slice.sv
      - source/axi_exclusive_monitor.sv
      - source/axi_sram_slave.sv
      - source/axi_excl_top.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - bench/axi_excl_chk.sv
      - bench/axi_excl_tb.sv

/* bench/axi_excl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_excl_settings.svh"

module axi_excl_tb;

    localparam int          NUM_TXNS     = 400;
    localparam int          TXN_CYCLES   = 40;
    localparam int          RESET_CYCLES = 8;
    localparam int          CLK_HALF     = 10;
    localparam int unsigned MEM_BYTES    = `AXI_EXCL_MEM_WORDS * `AXI_EXCL_STRB_WIDTH;

    logic                            clk;
    logic                            rst_n;
    logic                            awvalid;
    logic                            awready;
    logic [`AXI_EXCL_ID_WIDTH-1:0]   awid;
    logic [`AXI_EXCL_ADDR_WIDTH-1:0] awaddr;
    logic                            awlock;
    logic                            wvalid;
    logic                            wready;
    logic [`AXI_EXCL_DATA_WIDTH-1:0] wdata;
    logic [`AXI_EXCL_STRB_WIDTH-1:0] wstrb;
    logic                            bvalid;
    logic                            bready;
    logic [1:0]                      bresp;
    logic [`AXI_EXCL_ID_WIDTH-1:0]   bid;
    logic                            arvalid;
    logic                            arready;
    logic [`AXI_EXCL_ID_WIDTH-1:0]   arid;
    logic [`AXI_EXCL_ADDR_WIDTH-1:0] araddr;
    logic                            arlock;
    logic                            rvalid;
    logic                            rready;
    logic [1:0]                      rresp;
    logic [`AXI_EXCL_DATA_WIDTH-1:0] rdata;
    logic [`AXI_EXCL_ID_WIDTH-1:0]   rid;

    // Reference model of the memory and the single reservation
    logic [`AXI_EXCL_DATA_WIDTH-1:0] model_mem [`AXI_EXCL_MEM_WORDS];
    logic                            resv_valid;
    logic [`AXI_EXCL_ADDR_WIDTH-1:0] resv_addr;
    logic [`AXI_EXCL_ADDR_WIDTH-1:0] addr_pool [4] = '{32'h10, 32'h24, 32'h100, 32'h3fc};
    int                              errors;
    bit                              wr_open;
    bit                              rd_open;

    axi_excl_top dut (.*);

    always #(CLK_HALF) clk = ~clk;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Mostly the small pool so that reservations get hit, sometimes an address out of range
    function automatic logic [31:0] pick_addr();
        if ($urandom_range(0, 9) == 0) begin
            return ($urandom_range(0, 1) == 0) ? 32'h400 : 32'h1_0008;
        end
        return addr_pool[$urandom_range(0, 3)];
    endfunction

    task automatic write_txn(input logic [3:0] id, input logic [31:0] addr, input logic lock,
                             input logic [31:0] data, input logic [3:0] strb);
        bit          aw_pending;
        bit          w_pending;
        bit          got;
        bit          fail;
        int unsigned w_wait;
        logic [1:0]  got_resp;
        logic [3:0]  got_id;
        logic [1:0]  exp_resp;

        fail = lock && !(resv_valid && resv_addr == addr);
        if (addr >= MEM_BYTES) begin
            exp_resp = axi_excl_pkg::DECERR;
        end else begin
            exp_resp = (lock && !fail) ? axi_excl_pkg::EXOKAY : axi_excl_pkg::OKAY;
            if (!fail) begin
                for (int i = 0; i < `AXI_EXCL_STRB_WIDTH; i++) begin
                    if (strb[i]) begin
                        model_mem[addr >> 2][8*i +: 8] = data[8*i +: 8];
                    end
                end
            end
        end
        if (resv_valid && resv_addr == addr) begin
            resv_valid = 1'b0;
        end

        // W sometimes trails AW so the memory stalls the request
        w_wait     = $urandom_range(0, 3);
        awid       = id;
        awaddr     = addr;
        awlock     = lock;
        wdata      = data;
        wstrb      = strb;
        awvalid    = 1'b1;
        wvalid     = (w_wait == 0);
        wr_open    = 1'b1;
        aw_pending = 1'b1;
        w_pending  = 1'b1;
        while (aw_pending || w_pending) begin
            @(posedge clk);
            if (awvalid && awready) begin
                aw_pending = 1'b0;
            end
            if (wvalid && wready) begin
                w_pending = 1'b0;
            end
            @(negedge clk);
            if (w_wait > 0) begin
                w_wait--;
            end
            awvalid = aw_pending;
            wvalid  = w_pending && (w_wait == 0);
        end

        got = 1'b0;
        while (!got) begin
            bready = 1'($urandom_range(0, 1));
            @(posedge clk);
            if (bvalid && bready) begin
                got      = 1'b1;
                got_resp = bresp;
                got_id   = bid;
            end
            @(negedge clk);
        end
        bready  = 1'b0;
        wr_open = 1'b0;
        compare("bresp", got_resp, exp_resp);
        compare("bid", got_id, id);
    endtask

    task automatic read_txn(input logic [3:0] id, input logic [31:0] addr, input logic lock);
        bit          got;
        logic [1:0]  got_resp;
        logic [3:0]  got_id;
        logic [31:0] got_data;
        logic [1:0]  exp_resp;
        logic [31:0] exp_data;

        if (addr >= MEM_BYTES) begin
            exp_resp = axi_excl_pkg::DECERR;
            exp_data = '0;
        end else begin
            exp_resp = lock ? axi_excl_pkg::EXOKAY : axi_excl_pkg::OKAY;
            exp_data = model_mem[addr >> 2];
        end
        // Out of range still leaves a reservation behind
        if (lock) begin
            resv_valid = 1'b1;
            resv_addr  = addr;
        end

        arid    = id;
        araddr  = addr;
        arlock  = lock;
        arvalid = 1'b1;
        rd_open = 1'b1;
        do begin
            @(posedge clk);
            got = arready;
            @(negedge clk);
        end while (!got);
        arvalid = 1'b0;

        got = 1'b0;
        while (!got) begin
            rready = 1'($urandom_range(0, 1));
            @(posedge clk);
            if (rvalid && rready) begin
                got      = 1'b1;
                got_resp = rresp;
                got_id   = rid;
                got_data = rdata;
            end
            @(negedge clk);
        end
        rready  = 1'b0;
        rd_open = 1'b0;
        compare("rresp", got_resp, exp_resp);
        compare("rid", got_id, id);
        compare("rdata", got_data, exp_data);
    endtask

    // A response with nothing outstanding is a duplicate or a stray
    always @(posedge clk) begin
        if (rst_n && bvalid && !wr_open) begin
            errors++;
            $display("Write response appeared with no write outstanding at %0t", $time);
        end
        if (rst_n && rvalid && !rd_open) begin
            errors++;
            $display("Read response appeared with no read outstanding at %0t", $time);
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TXNS * TXN_CYCLES) @(posedge clk);
        $display("Timeout: transactions did not complete");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic        lock;

        void'($urandom(32'h13fd_8974));
        errors     = 0;
        wr_open    = 1'b0;
        rd_open    = 1'b0;
        resv_valid = 1'b0;
        resv_addr  = '0;
        for (int i = 0; i < `AXI_EXCL_MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        clk     = 1'b0;
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlock  = 1'b0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlock  = 1'b0;
        rready  = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        compare("awready", awready, 1'b0);
        compare("arready", arready, 1'b0);
        compare("wready", wready, 1'b0);
        compare("bvalid", bvalid, 1'b0);
        compare("rvalid", rvalid, 1'b0);
        rst_n = 1'b1;

        for (int n = 0; n < NUM_TXNS; n++) begin
            addr = pick_addr();
            lock = 1'($urandom_range(0, 1));
            if ($urandom_range(0, 9) < 4) begin
                read_txn(4'($urandom_range(0, 15)), addr, lock);
            end else begin
                write_txn(4'($urandom_range(0, 15)), addr, lock, $urandom(),
                          4'($urandom_range(0, 15)));
            end
        end

        $display("Transactions: %0d, errors: %0d", NUM_TXNS, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/axi_excl_chk.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_excl_settings.svh"

module axi_excl_chk (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            mem_awvalid,
    input logic                            mem_awready,
    input axi_excl_pkg::axi_aw_req_t       mem_aw,
    input logic                            mem_arvalid,
    input logic                            mem_arready,
    input axi_excl_pkg::axi_ar_req_t       mem_ar,
    input logic                            mem_wvalid,
    input logic                            mem_wready,
    input logic [`AXI_EXCL_STRB_WIDTH-1:0] mem_wstrb,
    input logic [`AXI_EXCL_STRB_WIDTH-1:0] cpu_wstrb,
    input logic                            bvalid,
    input logic                            bready,
    input axi_excl_pkg::axi_resp_e         bresp,
    input logic                            rvalid,
    input logic                            rready
);

    // Requests towards memory hold until taken
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_aw))
        else $error("AW request to memory dropped or changed before it was taken");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar))
        else $error("AR request to memory dropped or changed before it was taken");

    // Responses towards the CPU hold until taken
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Blanked strobes only come from a failed locked write, whose response is never EXOKAY
    strb_blank: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wvalid && mem_wready && cpu_wstrb != '0 && mem_wstrb == '0
        |-> mem_aw.lock ##1 bresp != axi_excl_pkg::EXOKAY)
        else $error("Strobes zeroed on a write without lock, or its response was EXOKAY");

endmodule

bind axi_exclusive_monitor axi_excl_chk chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_awvalid(mem.awvalid),
    .mem_awready(mem.awready),
    .mem_aw     (mem.aw),
    .mem_arvalid(mem.arvalid),
    .mem_arready(mem.arready),
    .mem_ar     (mem.ar),
    .mem_wvalid (mem.wvalid),
    .mem_wready (mem.wready),
    .mem_wstrb  (mem.wstrb),
    .cpu_wstrb  (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .rvalid     (rvalid),
    .rready     (rready)
);

`default_nettype wire

/* source/axi_excl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_excl_settings.svh"

module axi_excl_top (
    input  logic                            clk,
    input  logic                            rst_n,

    // Write address
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [`AXI_EXCL_ID_WIDTH-1:0]   awid,
    input  logic [`AXI_EXCL_ADDR_WIDTH-1:0] awaddr,
    input  logic                            awlock,

    // Write data and response
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [`AXI_EXCL_DATA_WIDTH-1:0] wdata,
    input  logic [`AXI_EXCL_STRB_WIDTH-1:0] wstrb,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    output logic [`AXI_EXCL_ID_WIDTH-1:0]   bid,

    // Read address
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [`AXI_EXCL_ID_WIDTH-1:0]   arid,
    input  logic [`AXI_EXCL_ADDR_WIDTH-1:0] araddr,
    input  logic                            arlock,

    // Read data
    output logic                            rvalid,
    input  logic                            rready,
    output logic [1:0]                      rresp,
    output logic [`AXI_EXCL_DATA_WIDTH-1:0] rdata,
    output logic [`AXI_EXCL_ID_WIDTH-1:0]   rid
);

    // Slice outputs towards the monitor
    logic                      aw_s_valid;
    logic                      aw_s_ready;
    axi_excl_pkg::axi_aw_req_t aw_s_req;
    logic                      ar_s_valid;
    logic                      ar_s_ready;
    axi_excl_pkg::axi_ar_req_t ar_s_req;

    axi_link_if mem_link ();

    axi_req_slice #(
        .req_t(axi_excl_pkg::axi_aw_req_t)
    ) aw_slice (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (awvalid),
        .in_ready (awready),
        .in_req   ({awid, awaddr, awlock}),
        .out_valid(aw_s_valid),
        .out_ready(aw_s_ready),
        .out_req  (aw_s_req)
    );

    axi_req_slice #(
        .req_t(axi_excl_pkg::axi_ar_req_t)
    ) ar_slice (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (arvalid),
        .in_ready (arready),
        .in_req   ({arid, araddr, arlock}),
        .out_valid(ar_s_valid),
        .out_ready(ar_s_ready),
        .out_req  (ar_s_req)
    );

    axi_exclusive_monitor monitor (
        .clk     (clk),
        .rst_n   (rst_n),
        .aw_valid(aw_s_valid),
        .aw_ready(aw_s_ready),
        .aw_req  (aw_s_req),
        .ar_valid(ar_s_valid),
        .ar_ready(ar_s_ready),
        .ar_req  (ar_s_req),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .bid     (bid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rresp   (rresp),
        .rdata   (rdata),
        .rid     (rid),
        .mem     (mem_link.host)
    );

    axi_sram_slave sram (
        .clk  (clk),
        .rst_n(rst_n),
        .bus  (mem_link.device)
    );

endmodule

`default_nettype wire

/* source/axi_sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_excl_settings.svh"

module axi_sram_slave (
    input  logic       clk,
    input  logic       rst_n,
    axi_link_if.device bus
);

    localparam int          BYTES_PER_WORD = `AXI_EXCL_STRB_WIDTH;
    localparam int          OFS_W          = $clog2(BYTES_PER_WORD);
    localparam int          IDX_W          = $clog2(`AXI_EXCL_MEM_WORDS);
    localparam int unsigned MEM_BYTES      = `AXI_EXCL_MEM_WORDS * BYTES_PER_WORD;

    logic [`AXI_EXCL_DATA_WIDTH-1:0] mem_q [`AXI_EXCL_MEM_WORDS] = '{default: '0};

    // Response registers
    logic                            b_valid;
    axi_excl_pkg::axi_resp_e         b_resp;
    logic [`AXI_EXCL_ID_WIDTH-1:0]   b_id;
    logic                            r_valid;
    axi_excl_pkg::axi_resp_e         r_resp;
    logic [`AXI_EXCL_DATA_WIDTH-1:0] r_data;
    logic [`AXI_EXCL_ID_WIDTH-1:0]   r_id;

    logic             busy;
    logic             wr_hs;
    logic             rd_hs;
    logic             wr_in_range;
    logic             rd_in_range;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // One response outstanding at a time
    assign busy = b_valid || r_valid;

    // AW and W are taken in the same cycle
    assign bus.awready = !busy && bus.wvalid;
    assign bus.wready  = !busy && bus.awvalid;
    assign bus.arready = !busy && !(bus.awvalid && bus.wvalid);

    assign wr_hs = bus.awvalid && bus.awready;
    assign rd_hs = bus.arvalid && bus.arready;

    assign wr_in_range = bus.aw.addr < MEM_BYTES;
    assign rd_in_range = bus.ar.addr < MEM_BYTES;
    assign wr_idx      = bus.aw.addr[OFS_W +: IDX_W];
    assign rd_idx      = bus.ar.addr[OFS_W +: IDX_W];

    assign bus.bvalid = b_valid;
    assign bus.bresp  = b_resp;
    assign bus.bid    = b_id;
    assign bus.rvalid = r_valid;
    assign bus.rresp  = r_resp;
    assign bus.rdata  = r_data;
    assign bus.rid    = r_id;

    // Byte-strobed write
    always_ff @(posedge clk) begin
        if (wr_hs && wr_in_range) begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                if (bus.wstrb[i]) begin
                    mem_q[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_hs) begin
                b_valid <= 1'b1;
            end else if (bus.bready) begin
                b_valid <= 1'b0;
            end
            if (rd_hs) begin
                r_valid <= 1'b1;
            end else if (bus.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            b_id   <= bus.aw.id;
            b_resp <= wr_in_range ? axi_excl_pkg::OKAY : axi_excl_pkg::DECERR;
        end
        if (rd_hs) begin
            r_id   <= bus.ar.id;
            r_resp <= rd_in_range ? axi_excl_pkg::OKAY : axi_excl_pkg::DECERR;
            r_data <= rd_in_range ? mem_q[rd_idx] : '0;
        end
    end

endmodule

`default_nettype wire

/* source/axi_exclusive_monitor.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_excl_settings.svh"

module axi_exclusive_monitor (
    input  logic                            clk,
    input  logic                            rst_n,

    // Requests from the slices
    input  logic                            aw_valid,
    output logic                            aw_ready,
    input  axi_excl_pkg::axi_aw_req_t       aw_req,
    input  logic                            ar_valid,
    output logic                            ar_ready,
    input  axi_excl_pkg::axi_ar_req_t       ar_req,

    // CPU write data and response
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [`AXI_EXCL_DATA_WIDTH-1:0] wdata,
    input  logic [`AXI_EXCL_STRB_WIDTH-1:0] wstrb,
    output logic                            bvalid,
    input  logic                            bready,
    output axi_excl_pkg::axi_resp_e         bresp,
    output logic [`AXI_EXCL_ID_WIDTH-1:0]   bid,

    // CPU read response
    output logic                            rvalid,
    input  logic                            rready,
    output axi_excl_pkg::axi_resp_e         rresp,
    output logic [`AXI_EXCL_DATA_WIDTH-1:0] rdata,
    output logic [`AXI_EXCL_ID_WIDTH-1:0]   rid,

    axi_link_if.host                        mem
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write
    } state_e;

    state_e state;
    logic   aw_done;
    logic   w_done;
    logic   ar_done;

    // Current transaction
    logic                            cur_lock;
    logic                            cur_fail;
    logic [`AXI_EXCL_ADDR_WIDTH-1:0] cur_addr;

    // The single reservation
    logic                            resv_valid;
    logic [`AXI_EXCL_ADDR_WIDTH-1:0] resv_addr;

    logic wr_active;
    logic rd_active;
    logic lock_fail;
    logic wr_fail;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic b_hs;
    logic r_hs;

    // Writes win when both requests show up in idle
    assign wr_active = (state == st_write) || (state == st_idle && aw_valid);
    assign rd_active = (state == st_read) || (state == st_idle && !aw_valid && ar_valid);

    // Locked write without a matching reservation must not reach memory
    assign lock_fail = aw_req.lock && !(resv_valid && resv_addr == aw_req.addr);
    assign wr_fail   = aw_done ? cur_fail : lock_fail;

    // AW and W forwarding
    assign mem.awvalid = wr_active && !aw_done && aw_valid;
    assign mem.aw      = aw_req;
    assign aw_ready    = wr_active && !aw_done && mem.awready;

    assign mem.wvalid  = wr_active && !w_done && wvalid;
    assign mem.wdata   = wdata;
    assign mem.wstrb   = wr_fail ? '0 : wstrb;
    assign wready      = wr_active && !w_done && mem.wready;

    // B returns once both halves of the write went out
    assign bvalid      = (state == st_write) && aw_done && w_done && mem.bvalid;
    assign mem.bready  = (state == st_write) && aw_done && w_done && bready;
    assign bid         = mem.bid;

    // AR forwarding and R return
    assign mem.arvalid = rd_active && !ar_done && ar_valid;
    assign mem.ar      = ar_req;
    assign ar_ready    = rd_active && !ar_done && mem.arready;

    assign rvalid      = (state == st_read) && ar_done && mem.rvalid;
    assign mem.rready  = (state == st_read) && ar_done && rready;
    assign rdata       = mem.rdata;
    assign rid         = mem.rid;

    assign aw_hs = mem.awvalid && mem.awready;
    assign w_hs  = mem.wvalid && mem.wready;
    assign ar_hs = mem.arvalid && mem.arready;
    assign b_hs  = bvalid && bready;
    assign r_hs  = rvalid && rready;

    // Only a clean OKAY is promoted, error codes pass through
    always_comb begin
        bresp = mem.bresp;
        if (mem.bresp == axi_excl_pkg::OKAY && cur_lock && !cur_fail) begin
            bresp = axi_excl_pkg::EXOKAY;
        end
    end

    always_comb begin
        rresp = mem.rresp;
        if (mem.rresp == axi_excl_pkg::OKAY && cur_lock) begin
            rresp = axi_excl_pkg::EXOKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
            ar_done    <= 1'b0;
            resv_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_valid) begin
                        state <= st_write;
                    end else if (ar_valid) begin
                        state <= st_read;
                    end
                end
                st_write: begin
                    if (b_hs) begin
                        state <= st_idle;
                    end
                end
                st_read: begin
                    if (r_hs) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            if (aw_hs) begin
                aw_done <= 1'b1;
            end
            if (w_hs) begin
                w_done <= 1'b1;
            end
            if (ar_hs) begin
                ar_done <= 1'b1;
            end

            if (b_hs) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
                // Any write to the reserved address ends the reservation
                if (resv_valid && resv_addr == cur_addr) begin
                    resv_valid <= 1'b0;
                end
            end

            if (r_hs) begin
                ar_done <= 1'b0;
                if (cur_lock) begin
                    resv_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            cur_lock <= aw_req.lock;
            cur_addr <= aw_req.addr;
            cur_fail <= lock_fail;
        end
        if (ar_hs) begin
            cur_lock <= ar_req.lock;
            cur_addr <= ar_req.addr;
        end
        if (r_hs && cur_lock) begin
            resv_addr <= cur_addr;
        end
    end

endmodule

`default_nettype wire

/* source/axi_req_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_req_slice #(
    parameter type req_t = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  req_t in_req,
    output logic out_valid,
    input  logic out_ready,
    output req_t out_req
);

    // Second entry catches the request taken while the output stalls
    logic skid_valid;
    req_t skid_req;
    logic accept;
    logic advance;

    assign accept  = in_valid && in_ready;
    assign advance = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else if (advance) begin
            // Output slot moves on, refill from skid first
            out_valid  <= skid_valid || accept;
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (accept) begin
            // Both entries now full
            skid_valid <= 1'b1;
            in_ready   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_req <= skid_valid ? skid_req : in_req;
        end
        if (!advance && accept) begin
            skid_req <= in_req;
        end
    end

endmodule

`default_nettype wire

/* source/axi_link_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_excl_settings.svh"

interface axi_link_if;

    // Write request and data
    logic                             awvalid;
    logic                             awready;
    axi_excl_pkg::axi_aw_req_t        aw;
    logic                             wvalid;
    logic                             wready;
    logic [`AXI_EXCL_DATA_WIDTH-1:0]  wdata;
    logic [`AXI_EXCL_STRB_WIDTH-1:0]  wstrb;

    // Write response
    logic                             bvalid;
    logic                             bready;
    axi_excl_pkg::axi_resp_e          bresp;
    logic [`AXI_EXCL_ID_WIDTH-1:0]    bid;

    // Read request and data
    logic                             arvalid;
    logic                             arready;
    axi_excl_pkg::axi_ar_req_t        ar;
    logic                             rvalid;
    logic                             rready;
    axi_excl_pkg::axi_resp_e          rresp;
    logic [`AXI_EXCL_DATA_WIDTH-1:0]  rdata;
    logic [`AXI_EXCL_ID_WIDTH-1:0]    rid;

    modport host (
        output awvalid, aw, wvalid, wdata, wstrb, bready, arvalid, ar, rready,
        input  awready, wready, bvalid, bresp, bid, arready, rvalid, rresp, rdata, rid
    );

    modport device (
        input  awvalid, aw, wvalid, wdata, wstrb, bready, arvalid, ar, rready,
        output awready, wready, bvalid, bresp, bid, arready, rvalid, rresp, rdata, rid
    );

endinterface

`default_nettype wire

/* source/axi_excl_pkg.sv */
`default_nettype none
`include "axi_excl_settings.svh"

package axi_excl_pkg;

    // AXI response codes as carried on BRESP and RRESP
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Single-beat write request
    typedef struct packed {
        logic [`AXI_EXCL_ID_WIDTH-1:0]   id;
        logic [`AXI_EXCL_ADDR_WIDTH-1:0] addr;
        logic                            lock;
    } axi_aw_req_t;

    // Single-beat read request
    typedef struct packed {
        logic [`AXI_EXCL_ID_WIDTH-1:0]   id;
        logic [`AXI_EXCL_ADDR_WIDTH-1:0] addr;
        logic                            lock;
    } axi_ar_req_t;

endpackage

`default_nettype wire

/* source/axi_excl_settings.svh */
`ifndef AXI_EXCL_SETTINGS_SVH
`define AXI_EXCL_SETTINGS_SVH

// Byte address and data bus widths
`define AXI_EXCL_ADDR_WIDTH 32
`define AXI_EXCL_DATA_WIDTH 32
`define AXI_EXCL_STRB_WIDTH (`AXI_EXCL_DATA_WIDTH / 8)

// Transaction ID width
`define AXI_EXCL_ID_WIDTH 4

// Words in the on-chip memory
`define AXI_EXCL_MEM_WORDS 256

`endif
